//--- vlog.f
+incdir+tb
hw/aoi_video_pkg.sv
hw/aoi_cfg_pkg.sv
hw/aoi_delay_line.sv
hw/aoi_ctrl.sv
hw/aoi_window_gen.sv
hw/aoi_output_stage.sv
hw/wb_aoi_sel.sv
tb/tb_wb_aoi_sel.sv

//--- tb/tb_frame_table.svh
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// pixel format codes as the register bank holds them
localparam logic [REG_W-1:0] PF_MONO8 = 32'h0108_0001;
localparam logic [REG_W-1:0] PF_MONO10 = 32'h0110_0003;
localparam logic [REG_W-1:0] PF_GR8 = 32'h0108_0008;
localparam logic [REG_W-1:0] PF_GR10 = 32'h0110_000C;

localparam int N_FRAMES = 10;

// one frame of stimulus
// blank = lval-low beats before every line and after the last one
typedef struct packed {
	int lines;
	int pixels;
	int blank;
	aoi_window_t win;
	logic [REG_W-1:0] fmt;
	logic [TEST_SEL_W-1:0] test_sel;
	logic int_en;
	logic armed;
} frame_row_t;

frame_row_t frame_tab [N_FRAMES];

// columns: lines, pixels, blank, {x_start, width, y_start, height},
// format, test select, interrupt enable, expected armed
task automatic fill_frame_table();
	frame_tab[0] = '{6, 16, 3, '{12'd4, 12'd8, 12'd1, 12'd3}, PF_GR8, 3'd0, 1'b1, 1'b1};
	frame_tab[1] = '{5, 12, 2, '{12'd0, 12'd12, 12'd0, 12'd5}, PF_GR10, 3'd0, 1'b1, 1'b1};
	frame_tab[2] = '{6, 16, 3, '{12'd2, 12'd4, 12'd2, 12'd2}, PF_MONO8, 3'd0, 1'b1, 1'b0};
	frame_tab[3] = '{6, 16, 3, '{12'd2, 12'd4, 12'd2, 12'd2}, PF_MONO10, 3'd0, 1'b1, 1'b0};
	frame_tab[4] = '{6, 16, 3, '{12'd3, 12'd5, 12'd1, 12'd2}, PF_GR10, 3'd2, 1'b1, 1'b0};
	frame_tab[5] = '{4, 10, 2, '{12'd2, 12'd0, 12'd1, 12'd2}, PF_GR8, 3'd0, 1'b1, 1'b0};
	frame_tab[6] = '{4, 10, 2, '{12'd2, 12'd3, 12'd1, 12'd0}, PF_GR8, 3'd0, 1'b1, 1'b0};
	frame_tab[7] = '{5, 14, 4, '{12'd5, 12'd6, 12'd2, 12'd3}, PF_GR8, 3'd0, 1'b0, 1'b0};
	frame_tab[8] = '{7, 20, 2, '{12'd19, 12'd1, 12'd6, 12'd1}, PF_GR10, 3'd0, 1'b1, 1'b1};
	frame_tab[9] = '{4, 8, 3, '{12'd1, 12'd6, 12'd1, 12'd2}, PF_GR8, 3'd0, 1'b1, 1'b1};
endtask

`endif

//--- tb/tb_wb_aoi_sel.sv
`timescale 1ns/1ps

module tb_wb_aoi_sel;
	import aoi_video_pkg::*;
	import aoi_cfg_pkg::*;

	`include "tb_frame_table.svh"

	// one input beat plus what the outputs owe it two cycles later
	typedef struct packed {
		frame_data_t video;
		color_flags_t flags;
		logic win;
		int frame;
		int row;
		int col;
	} beat_t;

	logic clk = 1'b0;
	logic i_rst_n;
	frame_data_t i_video;
	logic i_lval;
	color_flags_t i_flags;
	aoi_window_t i_window;
	logic [REG_W-1:0] i_pixel_format;
	logic [TEST_SEL_W-1:0] i_test_image_sel;
	logic i_interrupt_en;
	logic i_interrupt_pin;
	frame_data_t o_video;
	logic o_lval;
	color_flags_t o_flags;
	logic o_interrupt_en;
	coord_t o_win_width;
	coord_t o_win_height;

	// beats in flight through the DUT
	beat_t pipe [$];
	integer seed = 32'h4a37_2e3f;
	int cur_frame;
	int n_beats = 0;
	int n_errors = 0;
	int cycle_cnt = 0;
	int cycle_limit;
	// window of the last frame that raised the interrupt
	coord_t last_w;
	coord_t last_h;

	wb_aoi_sel i_wb_aoi_sel (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_video          (i_video),
		.i_lval           (i_lval),
		.i_flags          (i_flags),
		.i_window         (i_window),
		.i_pixel_format   (i_pixel_format),
		.i_test_image_sel (i_test_image_sel),
		.i_interrupt_en   (i_interrupt_en),
		.i_interrupt_pin  (i_interrupt_pin),
		.o_video          (o_video),
		.o_lval           (o_lval),
		.o_flags          (o_flags),
		.o_interrupt_en   (o_interrupt_en),
		.o_win_width      (o_win_width),
		.o_win_height     (o_win_height)
	);

	// 4 ns period
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: test did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ------------------------------
	// reference model
	// ------------------------------

	// bayer GR, even rows G R G R, odd rows B G B G
	function automatic color_flags_t bayer_flags(input int row, input int col);
		color_flags_t f;
		f = '0;
		if (row[0] == col[0]) f.g = 1'b1;
		else if (row[0] == 1'b0) f.r = 1'b1;
		else f.b = 1'b1;
		return f;
	endfunction

	// window is half open, start included and start + size excluded
	function automatic logic in_window(input frame_row_t fr, input int row, input int col);
		logic x_ok;
		logic y_ok;
		x_ok = (col >= int'(fr.win.x_start)) &&
			(col < int'(fr.win.x_start) + int'(fr.win.width));
		y_ok = (row >= int'(fr.win.y_start)) &&
			(row < int'(fr.win.y_start) + int'(fr.win.height));
		return fr.armed && x_ok && y_ok;
	endfunction

	// frame beats plus a fixed margin per frame for porch and gap
	function automatic int timeout_limit();
		int total;
		total = 100;
		for (int i = 0; i < N_FRAMES; i++) begin
			total += frame_tab[i].lines * (frame_tab[i].pixels + frame_tab[i].blank) + 20;
		end
		return total;
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp, input string where);
		n_errors++;
		$display("MISMATCH %s: got 0x%h, expected 0x%h (%s, %0t)", sig, got, exp, where, $time);
	endtask

	// ------------------------------
	// drive and compare
	// ------------------------------

	task automatic compare_beat(input beat_t b);
		color_flags_t exp_flags;
		string where;
		exp_flags = b.win ? b.flags : '0;
		where = $sformatf("frame %0d row %0d col %0d", b.frame, b.row, b.col);
		n_beats++;
		if (o_video !== b.video) report_mismatch("o_video", o_video, b.video, where);
		if (o_lval !== b.win) report_mismatch("o_lval", o_lval, b.win, where);
		if (o_flags !== exp_flags) report_mismatch("o_flags", o_flags, exp_flags, where);
	endtask

	// outputs seen here belong to the beat driven two falling edges back
	task automatic send_beat(input logic fval, input logic lval, input int row, input int col);
		beat_t b;
		@(negedge clk);
		if (pipe.size() == 2) compare_beat(pipe.pop_front());
		b.video.fval = fval;
		b.video.pix = pix_t'($random(seed));
		b.flags = lval ? bayer_flags(row, col) : '0;
		b.win = lval && in_window(frame_tab[cur_frame], row, col);
		b.frame = cur_frame;
		b.row = row;
		b.col = col;
		i_video = b.video;
		i_lval = lval;
		i_flags = b.flags;
		pipe.push_back(b);
	endtask

	task automatic drive_frame(input int idx);
		frame_row_t fr;
		fr = frame_tab[idx];
		cur_frame = idx;
		// register bank written while fval is low
		i_window = fr.win;
		i_pixel_format = fr.fmt;
		i_test_image_sel = fr.test_sel;
		i_interrupt_en = fr.int_en;
		send_beat(1'b0, 1'b0, 0, 0);
		for (int r = 0; r < fr.lines; r++) begin
			repeat (fr.blank) send_beat(1'b1, 1'b0, r, 0);
			for (int c = 0; c < fr.pixels; c++) begin
				send_beat(1'b1, 1'b1, r, c);
				// cleared in the last gap, only a frame end sets it again
				if (o_interrupt_en !== 1'b0) begin
					report_mismatch("o_interrupt_en", o_interrupt_en, 0, $sformatf("frame %0d", idx));
				end
			end
		end
		repeat (fr.blank) send_beat(1'b1, 1'b0, fr.lines, 0);
	endtask

	// gap after a frame, interrupt, size latch and interrupt clear
	task automatic close_frame(input int idx);
		frame_row_t fr;
		string where;
		fr = frame_tab[idx];
		where = $sformatf("frame %0d gap", idx);
		// o_fval is low by now
		repeat (4) send_beat(1'b0, 1'b0, 0, 0);
		if (o_interrupt_en !== fr.armed) report_mismatch("o_interrupt_en", o_interrupt_en, fr.armed, where);
		// firmware answers only a raised interrupt
		if (fr.armed) begin
			last_w = fr.win.width;
			last_h = fr.win.height;
			i_interrupt_pin = 1'b1;
		end
		send_beat(1'b0, 1'b0, 0, 0);
		i_interrupt_pin = 1'b0;
		send_beat(1'b0, 1'b0, 0, 0);
		if (o_win_width !== last_w) report_mismatch("o_win_width", o_win_width, last_w, where);
		if (o_win_height !== last_h) report_mismatch("o_win_height", o_win_height, last_h, where);
		i_interrupt_en = 1'b0;
		repeat (2) send_beat(1'b0, 1'b0, 0, 0);
		if (o_interrupt_en !== 1'b0) report_mismatch("o_interrupt_en", o_interrupt_en, 0, where);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		beat_t reset_beat;
		i_rst_n = 1'b0;
		i_video = '0;
		i_lval = 1'b0;
		i_flags = '0;
		i_window = '0;
		i_pixel_format = '0;
		i_test_image_sel = '0;
		i_interrupt_en = 1'b0;
		i_interrupt_pin = 1'b0;
		cur_frame = -1;
		last_w = '0;
		last_h = '0;
		fill_frame_table();
		cycle_limit = timeout_limit();
		// two zero beats in flight across reset release
		reset_beat = '0;
		reset_beat.frame = -1;
		pipe.push_back(reset_beat);
		pipe.push_back(reset_beat);
		repeat (2) @(negedge clk);
		i_rst_n = 1'b1;
		if (o_interrupt_en !== 1'b0) report_mismatch("o_interrupt_en", o_interrupt_en, 0, "reset");
		if (o_win_width !== '0) report_mismatch("o_win_width", o_win_width, 0, "reset");
		if (o_win_height !== '0) report_mismatch("o_win_height", o_win_height, 0, "reset");
		for (int f = 0; f < N_FRAMES; f++) begin
			drive_frame(f);
			close_frame(f);
		end
		// drain the last two beats
		repeat (2) send_beat(1'b0, 1'b0, 0, 0);
		$display("frames %0d, beats compared %0d, errors %0d", N_FRAMES, n_beats, n_errors);
		if (n_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- hw/wb_aoi_sel.sv
`timescale 1ns/1ps

module wb_aoi_sel (
	input  logic                               clk,
	input  logic                               i_rst_n,
	// video in
	input  aoi_video_pkg::frame_data_t         i_video,
	input  logic                               i_lval,
	input  aoi_video_pkg::color_flags_t        i_flags,
	// configuration from the register bank
	input  aoi_cfg_pkg::aoi_window_t           i_window,
	input  logic [aoi_cfg_pkg::REG_W-1:0]      i_pixel_format,
	input  logic [aoi_cfg_pkg::TEST_SEL_W-1:0] i_test_image_sel,
	input  logic                               i_interrupt_en,
	input  logic                               i_interrupt_pin,
	// video out
	output aoi_video_pkg::frame_data_t         o_video,
	output logic                               o_lval,
	output aoi_video_pkg::color_flags_t        o_flags,
	// status
	output logic                               o_interrupt_en,
	output aoi_cfg_pkg::coord_t                o_win_width,
	output aoi_cfg_pkg::coord_t                o_win_height
);
	import aoi_cfg_pkg::*;

	// captured window and arm from control
	aoi_window_t window_cap;
	logic win_arm;
	// window flag, one cycle behind the input pixel
	logic in_win;

	aoi_ctrl u_ctrl (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_fval           (i_video.fval),
		.i_window         (i_window),
		.i_pixel_format   (i_pixel_format),
		.i_test_image_sel (i_test_image_sel),
		.i_interrupt_en   (i_interrupt_en),
		.i_interrupt_pin  (i_interrupt_pin),
		.o_window_cap     (window_cap),
		.o_win_arm        (win_arm),
		.o_interrupt_en   (o_interrupt_en),
		.o_win_width      (o_win_width),
		.o_win_height     (o_win_height)
	);

	aoi_window_gen u_window_gen (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_fval       (i_video.fval),
		.i_lval       (i_lval),
		.i_window_cap (window_cap),
		.i_win_arm    (win_arm),
		.o_in_win     (in_win)
	);

	// two cycles to the pins
	aoi_output_stage u_output_stage (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_video  (i_video),
		.i_flags  (i_flags),
		.i_in_win (in_win),
		.o_video  (o_video),
		.o_lval   (o_lval),
		.o_flags  (o_flags)
	);

endmodule

//--- hw/aoi_output_stage.sv
`timescale 1ns/1ps

module aoi_output_stage (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  aoi_video_pkg::frame_data_t  i_video,
	input  aoi_video_pkg::color_flags_t i_flags,
	input  logic                        i_in_win,
	output aoi_video_pkg::frame_data_t  o_video,
	output logic                        o_lval,
	output aoi_video_pkg::color_flags_t o_flags
);
	import aoi_video_pkg::*;

	// flags after the first stage
	color_flags_t flags_d1;

	// ------------------------------
	// plain delay
	// ------------------------------

	// fval and pixel, untouched
	aoi_delay_line #(
		.payload_t (frame_data_t),
		.DEPTH     (VIDEO_DLY)
	) u_video_dly (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_d     (i_video),
		.o_q     (o_video)
	);

	// flags, one stage
	aoi_delay_line #(
		.payload_t (color_flags_t),
		.DEPTH     (FLAG_DLY)
	) u_flags_dly (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_d     (i_flags),
		.o_q     (flags_d1)
	);

	// ------------------------------
	// gated stage
	// ------------------------------

	// in_win already lags one cycle, one more flop aligns with o_video
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_lval <= 1'b0;
			o_flags <= '0;
		end else begin
			o_lval <= i_in_win;
			// outside the window flags read as zero
			o_flags <= i_in_win ? flags_d1 : '0;
		end
	end

endmodule

//--- hw/aoi_window_gen.sv
`timescale 1ns/1ps

module aoi_window_gen (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_fval,
	input  logic                     i_lval,
	input  aoi_cfg_pkg::aoi_window_t i_window_cap,
	input  logic                     i_win_arm,
	output logic                     o_in_win
);
	import aoi_cfg_pkg::*;

	// position counters
	coord_t pix_cnt;
	coord_t line_cnt;
	logic lval_d1;
	logic lval_fall;

	// window end, first position outside
	coord_t x_end;
	coord_t y_end;

	// direction enables
	logic x_en;
	logic y_en;
	logic x_en_nxt;
	logic y_en_nxt;

	// ------------------------------
	// counters
	// ------------------------------

	assign lval_fall = lval_d1 & ~i_lval;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			lval_d1 <= 1'b0;
			pix_cnt <= '0;
			line_cnt <= '0;
		end else begin
			lval_d1 <= i_lval;
			// column of the current pixel, zero on the first one
			if (!i_lval) begin
				pix_cnt <= '0;
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
			// row advances once per line, in blanking
			if (!i_fval) begin
				line_cnt <= '0;
			end else if (lval_fall) begin
				line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	// ------------------------------
	// window compare
	// ------------------------------

	assign x_end = i_window_cap.x_start + i_window_cap.width;
	assign y_end = i_window_cap.y_start + i_window_cap.height;

	// x: open at x_start, close at the end or when the line stops
	always_comb begin
		x_en_nxt = x_en;
		if (!i_win_arm || !i_lval) begin
			x_en_nxt = 1'b0;
		end else if (pix_cnt == i_window_cap.x_start) begin
			x_en_nxt = 1'b1;
		end else if (pix_cnt == x_end) begin
			x_en_nxt = 1'b0;
		end
	end

	// y: same on line count, held through the blanking
	always_comb begin
		y_en_nxt = y_en;
		if (!i_win_arm) begin
			y_en_nxt = 1'b0;
		end else if (line_cnt == i_window_cap.y_start) begin
			y_en_nxt = 1'b1;
		end else if (line_cnt == y_end) begin
			y_en_nxt = 1'b0;
		end
	end

	// in_win belongs to the pixel one cycle earlier
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			x_en <= 1'b0;
			y_en <= 1'b0;
			o_in_win <= 1'b0;
		end else begin
			x_en <= x_en_nxt;
			y_en <= y_en_nxt;
			o_in_win <= x_en_nxt & y_en_nxt;
		end
	end

endmodule

//--- hw/aoi_ctrl.sv
`timescale 1ns/1ps

module aoi_ctrl (
	input  logic                               clk,
	input  logic                               i_rst_n,
	input  logic                               i_fval,
	input  aoi_cfg_pkg::aoi_window_t           i_window,
	input  logic [aoi_cfg_pkg::REG_W-1:0]      i_pixel_format,
	input  logic [aoi_cfg_pkg::TEST_SEL_W-1:0] i_test_image_sel,
	input  logic                               i_interrupt_en,
	input  logic                               i_interrupt_pin,
	output aoi_cfg_pkg::aoi_window_t           o_window_cap,
	output logic                               o_win_arm,
	output logic                               o_interrupt_en,
	output aoi_cfg_pkg::coord_t                o_win_width,
	output aoi_cfg_pkg::coord_t                o_win_height
);
	import aoi_cfg_pkg::*;

	// frame valid history
	logic fval_d1;
	logic fval_d2;
	logic fval_rise;
	logic fval_fall;

	// interrupt pin edge
	logic int_pin_d1;
	logic int_pin_rise;

	// enable terms
	logic int_en_frame;
	logic [MONO_SIG_W-1:0] fmt_sig;
	logic mono_sel;
	logic zero_size;
	logic aoi_enable;

	// ------------------------------
	// edge detection
	// ------------------------------

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			fval_d1 <= 1'b0;
			fval_d2 <= 1'b0;
			int_pin_d1 <= 1'b0;
		end else begin
			fval_d1 <= i_fval;
			fval_d2 <= fval_d1;
			int_pin_d1 <= i_interrupt_pin;
		end
	end

	// rise seen on the input itself, window taken right away
	assign fval_rise = i_fval & ~fval_d1;
	// fall seen one stage late, lines up with the delayed video
	assign fval_fall = fval_d2 & ~fval_d1;
	assign int_pin_rise = i_interrupt_pin & ~int_pin_d1;

	// ------------------------------
	// enable terms
	// ------------------------------

	// interrupt enable sampled at frame start only
	// so a frame is either counted whole or not at all
	// clearing it takes effect at once
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			int_en_frame <= 1'b0;
		end else if (!i_interrupt_en) begin
			int_en_frame <= 1'b0;
		end else if (fval_rise) begin
			int_en_frame <= 1'b1;
		end
	end

	// mono formats carry no colour, statistics make no sense
	assign fmt_sig = {i_pixel_format[20], i_pixel_format[19], i_pixel_format[3:0]};

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			mono_sel <= 1'b0;
		end else begin
			case (fmt_sig)
				FMT_SIG_MONO8,
				FMT_SIG_MONO10: mono_sel <= 1'b1;
				default: mono_sel <= 1'b0;
			endcase
		end
	end

	// window capture at frame start
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_window_cap <= '0;
		end else if (fval_rise) begin
			o_window_cap <= i_window;
		end
	end

	// empty window, nothing to select
	assign zero_size = (o_window_cap.width == '0) || (o_window_cap.height == '0);

	assign aoi_enable = int_en_frame & ~mono_sel & ~zero_size &
		(i_test_image_sel == TEST_IMG_REAL);

	// window generator only runs inside the delayed frame
	assign o_win_arm = aoi_enable & fval_d1;

	// ------------------------------
	// interrupt and size latch
	// ------------------------------

	// set at the end of an enabled frame
	// any enable term dropping clears it
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_interrupt_en <= 1'b0;
		end else if (!aoi_enable) begin
			o_interrupt_en <= 1'b0;
		end else if (fval_fall) begin
			o_interrupt_en <= 1'b1;
		end
	end

	// size of the window the statistics belong to
	// held for firmware while it services the interrupt
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_win_width <= '0;
			o_win_height <= '0;
		end else if (int_pin_rise) begin
			o_win_width <= o_window_cap.width;
			o_win_height <= o_window_cap.height;
		end
	end

endmodule

//--- hw/aoi_delay_line.sv
`timescale 1ns/1ps

module aoi_delay_line #(
	parameter type payload_t = aoi_video_pkg::frame_data_t,
	parameter int  DEPTH     = 2
) (
	input  logic     clk,
	input  logic     i_rst_n,
	input  payload_t i_d,
	output payload_t o_q
);

	// shift chain, stage 0 nearest the input
	payload_t stage [DEPTH];

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= i_d;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign o_q = stage[DEPTH-1];

endmodule

//--- hw/aoi_cfg_pkg.sv
package aoi_cfg_pkg;

	// ------------------------------
	// register bank widths
	// ------------------------------

	// window coordinates, sizes and pixel/line counters
	localparam int WIN_W = 12;
	// pixel format register width
	localparam int REG_W = 32;
	// test image select width
	localparam int TEST_SEL_W = 3;

	// one coordinate or size
	typedef logic [WIN_W-1:0] coord_t;

	// statistics window, offsets relative to the active image
	typedef struct packed {
		coord_t x_start;
		coord_t width;
		coord_t y_start;
		coord_t height;
	} aoi_window_t;

	// ------------------------------
	// pixel format decode
	// ------------------------------

	// signature = {fmt[20], fmt[19], fmt[3:0]}
	// enough to tell the four supported formats apart
	localparam int MONO_SIG_W = 6;

	// Mono8    0x0108_0001 -> 0 1 0001
	// Mono10   0x0110_0003 -> 1 0 0011
	// BayerGR8 0x0108_0008 -> 0 1 1000
	// BayerGR10 0x0110_000C -> 1 0 1100
	localparam logic [MONO_SIG_W-1:0] FMT_SIG_MONO8 = 6'b01_0001;
	localparam logic [MONO_SIG_W-1:0] FMT_SIG_MONO10 = 6'b10_0011;

	// ------------------------------
	// test image select
	// ------------------------------

	// 000 real sensor image
	// anything else is a generated pattern, no statistics then
	localparam logic [TEST_SEL_W-1:0] TEST_IMG_REAL = 3'b000;

endpackage

//--- hw/aoi_video_pkg.sv
package aoi_video_pkg;

	// ------------------------------
	// pixel stream widths
	// ------------------------------

	// raw bayer sample width from the sensor
	localparam int PIX_W = 10;

	// fixed latency from input to output
	localparam int VIDEO_DLY = 2;
	// flags take one plain stage
	// the second stage is the gated one
	localparam int FLAG_DLY = 1;

	// ------------------------------
	// stream types
	// ------------------------------

	// one sensor sample
	typedef logic [PIX_W-1:0] pix_t;

	// bayer component of the current pixel
	// at most one bit high per pixel
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} color_flags_t;

	// frame framing plus pixel value
	// carried unchanged to the output, only delayed
	typedef struct packed {
		logic fval;
		pix_t pix;
	} frame_data_t;

	// line valid is not part of frame_data_t
	// the output line valid is rebuilt from the window
	// so the input one never reaches the output directly

endpackage
